// File: bench/texSampleTb.sv
//##########################################################
// Testbench for the UTX texel sampler.
// Sends fixed and random blocks, checks every texel against a
// reference decode and prints one line per test.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module texSampleTb;

	import texSamplerPkg::*;

	localparam int waitLimit = 200;

	logic clk = 1'b0;
	logic arstN;
	logic [`UTX_BLOCK_W-1:0] blockIn;
	utxMode modeIn;
	logic inReq;
	logic inAck;
	argbTexel texelOut;
	logic [`UTX_INDEX_W-1:0] texelIndex;
	logic outReq;
	logic outAck;
	integer seed;
	int testsRun;
	int testsFailed;
	int n;
	logic [`UTX_BLOCK_W-1:0] randomBlock;
	logic [31:0] draw;

	texSampleTop dut (
		.clk(clk),
		.arstN(arstN),
		.blockIn(blockIn),
		.modeIn(modeIn),
		.inReq(inReq),
		.inAck(inAck),
		.texelOut(texelOut),
		.texelIndex(texelIndex),
		.outReq(outReq),
		.outAck(outAck)
	);

	always #4 clk = ~clk;

	// 5/8 near plus 3/8 far, stretched so 248 maps to 255
	function automatic logic [7:0] blend58(input logic [4:0] near, input logic [4:0] far);
		int total;
		total = 5 * near + 3 * far;
		return 8'(total + total / 32);
	endfunction

	function automatic logic [31:0] widenColor(input logic [15:0] c, input logic alphaOn);
		logic [7:0] a;
		a = alphaOn ? {c[10], c[5], c[0], c[10], c[5], c[0], c[10], c[5]} : 8'hFF;
		return {a, c[14:10], c[14:12], c[9:5], c[9:7], c[4:0], c[4:2]};
	endfunction

	task automatic refTexel(input logic [`UTX_BLOCK_W-1:0] b, input utxMode m, input int i,
		output logic [`UTX_TEXEL_W-1:0] t);
		logic [7:0] spread;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] bl;
		logic [15:0] hi;
		logic [15:0] lo;
		logic [31:0] colM;
		logic [31:0] colN;
		logic [4:0] alphaHi;
		logic [4:0] alphaLo;
		logic alphaOn;
		logic selB;
		logic selA;
		if (m == modeUtx1)
		begin
			spread = {b[15:12], b[15:12]} >> 1;
			r = {b[11:8], b[11:8]};
			g = {b[7:4], b[7:4]};
			bl = {b[3:0], b[3:0]};
			if (b[16 + i])
				t = {8'hFF, r + spread, g + spread, bl + spread};
			else
				t = {8'hFF, r - spread, g - spread, bl - spread};
		end
		else
		begin
			hi = b[31:16];
			lo = b[15:0];
			alphaOn = b[15];
			colM = widenColor(hi, alphaOn);
			colN = widenColor(lo, alphaOn);
			selB = b[2 * i + 33];
			selA = b[2 * i + 32];
			alphaHi = {hi[10], hi[5], hi[0], 2'b00};
			alphaLo = {lo[10], lo[5], lo[0], 2'b00};
			if (b[15] != b[31])
				t = {selA ? colN[31:24] : colM[31:24], selB ? colN[23:0] : colM[23:0]};
			else if (selB == selA)
				t = selB ? colN : colM;
			else if (selB)
				t = {alphaOn ? blend58(alphaHi, alphaLo) : 8'hFF, blend58(hi[14:10], lo[14:10]),
					blend58(hi[9:5], lo[9:5]), blend58(hi[4:0], lo[4:0])};
			else
				t = {alphaOn ? blend58(alphaLo, alphaHi) : 8'hFF, blend58(lo[14:10], hi[14:10]),
					blend58(lo[9:5], hi[9:5]), blend58(lo[4:0], hi[4:0])};
		end
	endtask

	// polls inAck or outReq on rising edges until it reaches level
	task automatic awaitLevel(input bit onOutReq, input logic level, input string what);
		int cycles;
		for (cycles = 0; cycles < waitLimit; cycles++)
		begin
			if ((onOutReq ? outReq : inAck) === level)
				break;
			@(posedge clk);
		end
		if (cycles == waitLimit)
		begin
			$display("Timeout: %s did not happen within %0d cycles", what, waitLimit);
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic runBlock(input string name, input logic [`UTX_BLOCK_W-1:0] block,
		input utxMode mode);
		logic [`UTX_TEXEL_W-1:0] expected;
		int delay;
		int k;
		bit failed;
		failed = 1'b0;
		blockIn <= block;
		modeIn <= mode;
		inReq <= 1'b1;
		awaitLevel(1'b0, 1'b1, "inAck rise");
		inReq <= 1'b0;
		awaitLevel(1'b0, 1'b0, "inAck fall");
		for (k = 0; k < `UTX_TEXELS; k++)
		begin
			awaitLevel(1'b1, 1'b1, "outReq rise");
			refTexel(block, mode, k, expected);
			assert (texelIndex === `UTX_INDEX_W'(k))
			else
			begin
				$display("Fail %s index: expected %0d, actual %0d", name, k, texelIndex);
				failed = 1'b1;
			end
			assert (texelOut === expected)
			else
			begin
				$display("Fail %s texel %0d: expected %h, actual %h", name, k, expected, texelOut);
				failed = 1'b1;
			end
			// sink back-pressure of 0 to 5 cycles
			delay = {$random(seed)} % 6;
			repeat (delay) @(posedge clk);
			outAck <= 1'b1;
			awaitLevel(1'b1, 1'b0, "outReq fall");
			outAck <= 1'b0;
		end
		testsRun++;
		if (failed)
			testsFailed++;
		$display("%s: %s", name, failed ? "failed" : "ok");
	endtask

	initial
	begin
		seed = 32'hca53;
		testsRun = 0;
		testsFailed = 0;
		arstN = 1'b0;
		blockIn = '0;
		modeIn = modeUtx1;
		inReq = 1'b0;
		outAck = 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);

		runBlock("utx1 flat", 64'h0000_0000_A5C3_0F4C, modeUtx1);
		runBlock("utx1 spread", 64'h1234_5678_5AF0_F3C9, modeUtx1);
		runBlock("utx2 opaque", 64'h1B4E_D872_C21F_3A95, modeUtx2);
		// E4 bytes walk through all four selector pairs
		runBlock("utx2 lerp", 64'hE4E4_E4E4_5A3C_1F87, modeUtx2);
		runBlock("utx2 alpha split", 64'h1B1B_E4E4_3D6A_9C35, modeUtx2);
		runBlock("utx2 alpha lerp", 64'hE4E4_1B1B_B3C5_A5F3, modeUtx2);

		for (n = 0; n < 20; n++)
		begin
			randomBlock = {$random(seed), $random(seed)};
			draw = $random(seed);
			runBlock($sformatf("stream %0d", n), randomBlock, utxMode'(draw[0]));
		end

		repeat (4) @(posedge clk);
		$display("Tests run %0d, failed %0d, protocol assertion failures %0d",
			testsRun, testsFailed, dut.protocolCheck.violationCount);
		if (testsFailed == 0 && dut.protocolCheck.violationCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/texSample_checker.sv
//##########################################################
// Protocol assertions for the texel sampler handshakes.
// Bound into the top level; each failure raises $error and
// bumps a counter that the testbench reads at the end.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module texSample_checker (
	input  logic clk,
	input  logic arstN,
	input  logic inReq,
	input  logic inAck,
	input  logic outReq,
	input  logic outAck,
	input  texSamplerPkg::argbTexel texelOut,
	input  logic [`UTX_INDEX_W-1:0] texelIndex
);

	int violationCount = 0;

	// ack only answers a pending request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(inAck) |-> $past(inReq))
	else
	begin
		violationCount++;
		$error("inAck rose without a pending inReq");
	end

	// presented data must hold for the whole request
	outputHeld: assert property (@(posedge clk) disable iff (!arstN)
		(outReq && $past(outReq)) |-> ($stable(texelOut) && $stable(texelIndex)))
	else
	begin
		violationCount++;
		$error("texelOut or texelIndex changed while outReq was high");
	end

	// outAck as seen on the edge that raised outReq
	outReqAfterRelease: assert property (@(posedge clk) disable iff (!arstN)
		$rose(outReq) |-> !$past(outAck))
	else
	begin
		violationCount++;
		$error("outReq rose while outAck was still high");
	end

	// the two handshakes never overlap
	oneSideBusy: assert property (@(posedge clk) disable iff (!arstN)
		!(inAck && outReq))
	else
	begin
		violationCount++;
		$error("inAck and outReq were high together");
	end

endmodule

bind texSampleTop texSample_checker protocolCheck (.*);

// File: rtl/texSampleCtrl.sv
//##########################################################
// Sequencer for the texel sampler.
// Accepts a block over a req/ack handshake, then presents
// each texel over a second req/ack handshake, index 0 to 15.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module texSampleCtrl (
	input  logic clk,
	input  logic arstN,
	input  logic [`UTX_BLOCK_W-1:0] blockIn,
	input  texSamplerPkg::utxMode modeIn,
	input  logic inReq,
	output logic inAck,
	input  logic outAck,
	output logic outReq,
	input  logic isLast,
	output logic counterClear,
	output logic counterStep,
	input  texSamplerPkg::argbTexel texel,
	output logic [`UTX_BLOCK_W-1:0] block,
	output texSamplerPkg::utxMode mode,
	output texSamplerPkg::argbTexel texelOut
);

	typedef enum logic [2:0]
	{
		stateIdle,
		stateCaptureRelease,
		stateLoad,
		statePresent,
		stateWaitRelease
	} ctrlState;

	ctrlState state;

	// capture happens on the same cycle the counter is cleared
	assign counterClear = (state == stateIdle) && inReq;
	assign counterStep = (state == stateWaitRelease) && !outAck && !isLast;

	always_ff @(posedge clk)
	begin
		if (counterClear)
		begin
			block <= blockIn;
			mode <= modeIn;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stateIdle;
			inAck <= 1'b0;
			outReq <= 1'b0;
			texelOut <= '0;
		end
		else
		begin
			case (state)
				stateIdle:
					if (inReq)
					begin
						inAck <= 1'b1;
						state <= stateCaptureRelease;
					end
				stateCaptureRelease:
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= stateLoad;
					end
				stateLoad:
				begin
					// decoder output already reflects the current index
					texelOut <= texel;
					outReq <= 1'b1;
					state <= statePresent;
				end
				statePresent:
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= stateWaitRelease;
					end
				stateWaitRelease:
					if (!outAck)
						state <= isLast ? stateIdle : stateLoad;
				default:
					state <= stateIdle;
			endcase
		end
	end

endmodule

// File: rtl/texSampleTop.sv
//##########################################################
// Top level of the UTX texel sampler.
// Takes one compressed block per input handshake and streams
// its 16 ARGB texels out over the output handshake.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module texSampleTop (
	input  logic clk,
	input  logic arstN,
	input  logic [`UTX_BLOCK_W-1:0] blockIn,
	input  texSamplerPkg::utxMode modeIn,
	input  logic inReq,
	output logic inAck,
	output texSamplerPkg::argbTexel texelOut,
	output logic [`UTX_INDEX_W-1:0] texelIndex,
	output logic outReq,
	input  logic outAck
);

	import texSamplerPkg::*;

	logic counterClear;
	logic counterStep;
	logic isLast;
	logic [`UTX_BLOCK_W-1:0] block;
	utxMode mode;
	argbTexel texel;

	texSampleCtrl ctrl (
		.clk(clk),
		.arstN(arstN),
		.blockIn(blockIn),
		.modeIn(modeIn),
		.inReq(inReq),
		.inAck(inAck),
		.outAck(outAck),
		.outReq(outReq),
		.isLast(isLast),
		.counterClear(counterClear),
		.counterStep(counterStep),
		.texel(texel),
		.block(block),
		.mode(mode),
		.texelOut(texelOut)
	);

	// index drives both the decoder and the output port
	texelIndexCounter counter (
		.clk(clk),
		.arstN(arstN),
		.clear(counterClear),
		.step(counterStep),
		.index(texelIndex),
		.isLast(isLast)
	);

	utxBlockDecoder decoder (
		.block(block),
		.mode(mode),
		.index(texelIndex),
		.texel(texel)
	);

endmodule

// File: rtl/texSamplerPkg.sv
//##########################################################
// Shared types for the UTX texel sampler.
// Compile before any module that uses the format or texel types.
//##########################################################

`include "texSampler_consts.svh"

package texSamplerPkg;

	// block format select, matches the texture unit's mode bit
	typedef enum logic
	{
		modeUtx1 = 1'b0,
		modeUtx2 = 1'b1
	} utxMode;

	// one decoded texel, alpha in the top byte
	typedef struct packed
	{
		logic [`UTX_TEXEL_W/4-1:0] alpha;
		logic [`UTX_TEXEL_W/4-1:0] red;
		logic [`UTX_TEXEL_W/4-1:0] green;
		logic [`UTX_TEXEL_W/4-1:0] blue;
	} argbTexel;

endpackage

// File: rtl/texSampler_consts.svh
//##########################################################
// Width and count constants for the UTX texel sampler.
// Include wherever block, texel or index widths are needed.
//##########################################################

`ifndef TEXSAMPLER_CONSTS_SVH
`define TEXSAMPLER_CONSTS_SVH

// one compressed block word
`define UTX_BLOCK_W 64
// one ARGB texel
`define UTX_TEXEL_W 32
// index into the 4x4 block
`define UTX_INDEX_W 4
`define UTX_TEXELS 16

`endif

// File: rtl/texelIndexCounter.sv
//##########################################################
// Texel index counter for one 4x4 block.
// Cleared at block capture, stepped after each texel is sent.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module texelIndexCounter (
	input  logic clk,
	input  logic arstN,
	input  logic clear,
	input  logic step,
	output logic [`UTX_INDEX_W-1:0] index,
	output logic isLast
);

	localparam logic [`UTX_INDEX_W-1:0] lastIndex = `UTX_INDEX_W'(`UTX_TEXELS - 1);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (step)
			index <= index + 1'b1;
	end

	// final texel of the block
	assign isLast = (index == lastIndex);

endmodule

// File: rtl/utxBlockDecoder.sv
//##########################################################
// Combinational UTX1/UTX2 block decoder.
// Given a block word, its format and a texel index, returns
// the ARGB value of that texel with no latency.
//##########################################################

`timescale 1ns/1ps

`include "texSampler_consts.svh"

module utxBlockDecoder (
	input  logic [`UTX_BLOCK_W-1:0] block,
	input  texSamplerPkg::utxMode mode,
	input  logic [`UTX_INDEX_W-1:0] index,
	output texSamplerPkg::argbTexel texel
);

	import texSamplerPkg::*;

	logic [7:0] dWide;
	logic [7:0] spread;
	logic [7:0] centerR;
	logic [7:0] centerG;
	logic [7:0] centerB;
	argbTexel utx1Low;
	argbTexel utx1High;
	logic [15:0] utx1Bits;
	logic utx1Sel;
	logic [15:0] colorA;
	logic [15:0] colorB;
	logic [4:0] alphaBitsA;
	logic [4:0] alphaBitsB;
	argbTexel colorM;
	argbTexel colorN;
	argbTexel blendNearB;
	argbTexel blendNearA;
	logic [15:0] selVecB;
	logic [15:0] selVecA;
	logic selB;
	logic selA;
	logic alphaMode;
	logic interpOn;

	// UTX1: center color plus/minus half the nibble-widened delta
	assign dWide = {block[15:12], block[15:12]};
	assign spread = {1'b0, dWide[7:1]};
	assign centerR = {block[11:8], block[11:8]};
	assign centerG = {block[7:4], block[7:4]};
	assign centerB = {block[3:0], block[3:0]};
	assign utx1Low = '{8'hFF, centerR - spread, centerG - spread, centerB - spread};
	assign utx1High = '{8'hFF, centerR + spread, centerG + spread, centerB + spread};
	assign utx1Bits = block[31:16];
	assign utx1Sel = utx1Bits[index];

	// UTX2: two RGB555 endpoints, M from the upper half
	assign colorB = block[31:16];
	assign colorA = block[15:0];
	assign alphaMode = block[15];
	assign interpOn = (block[15] == block[31]);

	// alpha from the channel LSBs, repeated R G B R G B R G
	assign colorM.alpha = alphaMode ?
		{colorB[10], colorB[5], colorB[0], colorB[10], colorB[5], colorB[0],
		colorB[10], colorB[5]} : 8'hFF;
	assign colorM.red = {colorB[14:10], colorB[14:12]};
	assign colorM.green = {colorB[9:5], colorB[9:7]};
	assign colorM.blue = {colorB[4:0], colorB[4:2]};

	assign colorN.alpha = alphaMode ?
		{colorA[10], colorA[5], colorA[0], colorA[10], colorA[5], colorA[0],
		colorA[10], colorA[5]} : 8'hFF;
	assign colorN.red = {colorA[14:10], colorA[14:12]};
	assign colorN.green = {colorA[9:5], colorA[9:7]};
	assign colorN.blue = {colorA[4:0], colorA[4:2]};

	// selector pairs sit interleaved in the upper word, B on odd bits
	for (genvar i = 0; i < `UTX_TEXELS; i++)
	begin : gSel
		assign selVecB[i] = block[2*i+33];
		assign selVecA[i] = block[2*i+32];
	end
	assign selB = selVecB[index];
	assign selA = selVecA[index];

	assign alphaBitsA = {colorA[10], colorA[5], colorA[0], 2'b00};
	assign alphaBitsB = {colorB[10], colorB[5], colorB[0], 2'b00};

	utxColorLerp lerpBr (.near(colorB[14:10]), .far(colorA[14:10]), .blended(blendNearB.red));
	utxColorLerp lerpBg (.near(colorB[9:5]), .far(colorA[9:5]), .blended(blendNearB.green));
	utxColorLerp lerpBb (.near(colorB[4:0]), .far(colorA[4:0]), .blended(blendNearB.blue));
	utxColorLerp lerpBa (.near(alphaBitsB), .far(alphaBitsA), .blended(blendNearB.alpha));

	utxColorLerp lerpAr (.near(colorA[14:10]), .far(colorB[14:10]), .blended(blendNearA.red));
	utxColorLerp lerpAg (.near(colorA[9:5]), .far(colorB[9:5]), .blended(blendNearA.green));
	utxColorLerp lerpAb (.near(colorA[4:0]), .far(colorB[4:0]), .blended(blendNearA.blue));
	utxColorLerp lerpAa (.near(alphaBitsA), .far(alphaBitsB), .blended(blendNearA.alpha));

	always_comb
	begin
		if (mode == modeUtx1)
		begin
			texel = utx1Sel ? utx1High : utx1Low;
		end
		else if (interpOn)
		begin
			case ({selB, selA})
				2'b00: texel = colorM;
				2'b01: texel = blendNearA;
				2'b10: texel = blendNearB;
				default: texel = colorN;
			endcase
			// blended alpha only counts in alpha mode
			if (!alphaMode)
				texel.alpha = 8'hFF;
		end
		else
		begin
			texel = selB ? colorN : colorM;
			texel.alpha = selA ? colorN.alpha : colorM.alpha;
		end
	end

endmodule

// File: rtl/utxColorLerp.sv
//##########################################################
// Two-color blend for UTX2 interpolation.
// Mixes 5/8 of near with 3/8 of far, widened to 8 bits.
//##########################################################

`timescale 1ns/1ps

module utxColorLerp (
	input  logic [4:0] near,
	input  logic [4:0] far,
	output logic [7:0] blended
);

	logic [7:0] nearTimes5;
	logic [7:0] farTimes3;
	logic [7:0] sum;

	// shift-and-add multiplies, both fit in 8 bits
	assign nearTimes5 = {1'b0, near, 2'b00} + {3'b000, near};
	assign farTimes3 = {2'b00, far, 1'b0} + {3'b000, far};

	// at most 5*31 + 3*31 = 248
	assign sum = nearTimes5 + farTimes3;

	// fold the top bits back in so full scale reaches 255
	assign blended = sum + {5'b00000, sum[7:5]};

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the texel sampler testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module texSampleTb -Mdir obj_dir -f sources.f
./obj_dir/VtexSampleTb +verilator+error+limit+1000 | tee sim.log

if grep -qx "Simulation passed" sim.log
then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

// File: sources.f
+incdir+rtl
rtl/texSamplerPkg.sv
rtl/utxColorLerp.sv
rtl/utxBlockDecoder.sv
rtl/texelIndexCounter.sv
rtl/texSampleCtrl.sv
rtl/texSampleTop.sv
bench/texSample_checker.sv
bench/texSampleTb.sv
